// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_alu_vector_runner
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== design/alu_core.sv ====
`timescale 1ns/1ns

module alu_core #(
  parameter int width = alu_pkg::word_width
) (
  input  logic             clk_1M,
  input  logic             reset,
  alu_req_if.sink          req,
  output logic [width-1:0] result,
  output logic [15:0]      flags
);
  import alu_pkg::*;

  localparam int msb = width - 1;

  logic             carry_in;
  logic [width-1:0] op_x;
  logic [width-1:0] op_y;
  logic             op_c;
  logic             op_sub;
  logic             keep_c;
  logic [width:0]   wide;
  logic [width-1:0] sum;
  logic             c_out;
  logic             o_out;
  logic             a_out;
  logic [width-1:0] next_result;
  logic [15:0]      next_flags;

  // Stored C, or a forced one from the vector
  assign carry_in = flags[flag_c] | req.force_carry;

  // Map each function onto one adder or subtractor
  always_comb begin
    op_x   = req.a;
    op_y   = req.b;
    op_c   = 1'b0;
    op_sub = 1'b0;
    keep_c = 1'b0;
    case (req.func)
      func_add: op_c = 1'b0;
      func_adc: op_c = carry_in;
      func_inc: begin
        op_y   = width'(1);
        keep_c = 1'b1;
      end
      func_dec: begin
        op_y   = width'(1);
        op_sub = 1'b1;
        keep_c = 1'b1;
      end
      // 0 - a, borrow out is set for any nonzero a
      func_neg: begin
        op_x   = '0;
        op_y   = req.a;
        op_sub = 1'b1;
      end
      func_sub, func_cmp: op_sub = 1'b1;
      func_sbb: begin
        op_sub = 1'b1;
        op_c   = carry_in;
      end
      default: op_c = 1'b0;
    endcase
  end

  // Extra top bit holds carry or borrow out
  assign wide = op_sub ? ({1'b0, op_x} - {1'b0, op_y} - {{width{1'b0}}, op_c})
                       : ({1'b0, op_x} + {1'b0, op_y} + {{width{1'b0}}, op_c});
  assign sum  = wide[width-1:0];

  assign c_out = keep_c ? flags[flag_c] : wide[width];

  // Signed overflow from the operand and result signs
  assign o_out = op_sub ? ((op_x[msb] != op_y[msb]) && (sum[msb] != op_x[msb]))
                        : ((op_x[msb] == op_y[msb]) && (sum[msb] != op_x[msb]));

  // Carry or borrow from bit 3 into bit 4
  assign a_out = op_x[4] ^ op_y[4] ^ sum[4];

  assign next_result = (req.func == func_cmp) ? req.a : sum;

  always_comb begin
    next_flags         = flags_reset;
    next_flags[flag_c] = c_out;
    next_flags[flag_p] = ~^sum[7:0];
    next_flags[flag_a] = a_out;
    next_flags[flag_z] = (sum == '0);
    next_flags[flag_s] = sum[msb];
    next_flags[flag_o] = o_out;
  end

  always_ff @(posedge clk_1M) begin
    if (reset) begin
      result <= '0;
      flags  <= flags_reset;
    end else if (req.issue) begin
      result <= next_result;
      flags  <= next_flags;
    end
  end

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

  // Operand and result width of the arithmetic group
  localparam int word_width = 16;

  // Arithmetic group function codes
  typedef enum logic [2:0] {
    func_add = 3'd0,
    func_adc = 3'd1,
    func_inc = 3'd2,
    func_dec = 3'd3,
    func_neg = 3'd4,
    func_sub = 3'd5,
    func_sbb = 3'd6,
    func_cmp = 3'd7
  } alu_func_e;

  // Bit positions in the x86-style flags word
  localparam int flag_c = 0;
  localparam int flag_p = 2;
  localparam int flag_a = 4;
  localparam int flag_z = 6;
  localparam int flag_s = 7;
  localparam int flag_o = 11;

  // Bit 1 always reads as one, all other unused bits as zero
  localparam logic [15:0] flags_reset = 16'h0002;

endpackage

// ==== design/alu_req_if.sv ====
`timescale 1ns/1ns

interface alu_req_if #(
  parameter int width = alu_pkg::word_width
);
  import alu_pkg::*;

  // Single-cycle strobe, payload valid with it
  logic             issue;
  logic [width-1:0] a;
  logic [width-1:0] b;
  alu_func_e        func;
  logic             force_carry;

  modport source (output issue, output a, output b, output func, output force_carry);
  modport sink (input issue, input a, input b, input func, input force_carry);

endinterface

// ==== design/alu_vector_runner.sv ====
`timescale 1ns/1ns

module alu_vector_runner #(
  parameter int width = alu_pkg::word_width
) (
  input  logic             clk_1M,
  input  logic             reset,
  input  logic             sw0_n,
  input  logic             sw1_n,
  output logic [7:0]       led,
  output logic [width-1:0] result,
  output logic [15:0]      flags
);
  import vector_pkg::*;

  logic [5:0]   index;
  test_vector_t vec;

  // Sequencer to ALU request path
  alu_req_if #(.width(width)) req ();

  step_sequencer u_sequencer (
    .clk_1M (clk_1M),
    .reset  (reset),
    .sw0_n  (sw0_n),
    .sw1_n  (sw1_n),
    .index  (index),
    .vec    (vec),
    .led    (led),
    .req    (req.source)
  );

  vector_rom u_rom (
    .index (index),
    .vec   (vec)
  );

  alu_core #(.width(width)) u_alu (
    .clk_1M (clk_1M),
    .reset  (reset),
    .req    (req.sink),
    .result (result),
    .flags  (flags)
  );

endmodule

// ==== design/step_sequencer.sv ====
`timescale 1ns/1ns

module step_sequencer (
  input  logic                     clk_1M,
  input  logic                     reset,
  input  logic                     sw0_n,
  input  logic                     sw1_n,
  output logic [5:0]               index,
  input  vector_pkg::test_vector_t vec,
  output logic [7:0]               led,
  alu_req_if.source                req
);
  import vector_pkg::*;

  typedef enum logic [1:0] {
    st_start,
    st_wait_sw,
    st_issue,
    st_done
  } state_e;

  state_e state;
  logic   sw_pressed;
  logic   last_vec;
  logic   load_vec;

  // Odd vector numbers wait for sw0, even ones for sw1
  assign sw_pressed = index[0] ? ~sw0_n : ~sw1_n;
  assign last_vec   = (index == 6'(vector_count - 1));

  // Vector 0 goes out straight after reset
  assign load_vec = (state == st_start) || (state == st_issue);

  always_ff @(posedge clk_1M) begin
    if (reset) begin
      state     <= st_start;
      index     <= 6'd0;
      led       <= 8'd0;
      req.issue <= 1'b0;
    end else begin
      req.issue <= 1'b0;
      case (state)
        st_start, st_issue: begin
          req.issue <= 1'b1;
          index     <= index + 6'd1;
          led       <= led + 8'd1;
          state     <= last_vec ? st_done : st_wait_sw;
        end
        st_wait_sw: begin
          if (sw_pressed) begin
            state <= st_issue;
          end
        end
        // Table exhausted, switches ignored
        st_done: state <= st_done;
        default: state <= st_start;
      endcase
    end
  end

  // Request payload, only meaningful while issue is high
  always_ff @(posedge clk_1M) begin
    if (load_vec) begin
      req.a           <= vec.a;
      req.b           <= vec.b;
      req.func        <= vec.func;
      req.force_carry <= vec.force_carry;
    end
  end

endmodule

// ==== design/vector_pkg.sv ====
package vector_pkg;

  // One entry of the test table
  typedef struct packed {
    logic [alu_pkg::word_width-1:0] a;
    logic [alu_pkg::word_width-1:0] b;
    alu_pkg::alu_func_e             func;
    // Set C before the operation runs
    logic                           force_carry;
  } test_vector_t;

  localparam int vector_count = 36;

endpackage

// ==== design/vector_rom.sv ====
`timescale 1ns/1ns

module vector_rom (
  input  logic [5:0]               index,
  output vector_pkg::test_vector_t vec
);
  import alu_pkg::*;

  always_comb begin
    case (index)
      // Add, first entry runs without a switch
      6'd0:  vec = '{16'hffff, 16'h0001, func_add, 1'b0};
      6'd1:  vec = '{16'hffff, 16'hffff, func_add, 1'b0};
      6'd2:  vec = '{16'h0001, 16'h0002, func_add, 1'b0};
      6'd3:  vec = '{16'h7fff, 16'h0001, func_add, 1'b0};
      6'd4:  vec = '{16'h8000, 16'hffff, func_add, 1'b0};
      6'd5:  vec = '{16'h1a62, 16'hed8a, func_add, 1'b0};
      // Add with carry, C comes from the previous add
      6'd6:  vec = '{16'hffff, 16'hffff, func_adc, 1'b0};
      6'd7:  vec = '{16'h0001, 16'h0002, func_adc, 1'b0};
      6'd8:  vec = '{16'h7fff, 16'h0001, func_adc, 1'b0};
      6'd9:  vec = '{16'h8000, 16'hffff, func_adc, 1'b0};
      6'd10: vec = '{16'h027f, 16'h846c, func_adc, 1'b0};
      // Increment and decrement, b unused
      6'd11: vec = '{16'hffff, 16'h0000, func_inc, 1'b0};
      6'd12: vec = '{16'h7fff, 16'h0000, func_inc, 1'b0};
      6'd13: vec = '{16'h4513, 16'h0000, func_inc, 1'b0};
      6'd14: vec = '{16'h0000, 16'h0000, func_dec, 1'b0};
      6'd15: vec = '{16'h8000, 16'h0000, func_dec, 1'b0};
      6'd16: vec = '{16'hc7db, 16'h0000, func_dec, 1'b0};
      // Negate, 8000 overflows
      6'd17: vec = '{16'h0000, 16'h0000, func_neg, 1'b0};
      6'd18: vec = '{16'h8000, 16'h0000, func_neg, 1'b0};
      6'd19: vec = '{16'hfac4, 16'h0000, func_neg, 1'b0};
      // Subtract
      6'd20: vec = '{16'h0001, 16'h0002, func_sub, 1'b0};
      6'd21: vec = '{16'hffff, 16'hffff, func_sub, 1'b0};
      6'd22: vec = '{16'hffff, 16'h0001, func_sub, 1'b0};
      6'd23: vec = '{16'h8000, 16'h0001, func_sub, 1'b0};
      6'd24: vec = '{16'ha627, 16'h03c5, func_sub, 1'b1};
      // Subtract with borrow
      6'd25: vec = '{16'h0001, 16'h0002, func_sbb, 1'b0};
      6'd26: vec = '{16'hffff, 16'hffff, func_sbb, 1'b0};
      6'd27: vec = '{16'hffff, 16'h0001, func_sbb, 1'b0};
      6'd28: vec = '{16'h8000, 16'h0001, func_sbb, 1'b0};
      6'd29: vec = '{16'ha627, 16'h03c5, func_sbb, 1'b1};
      // Compare, result stays a
      6'd30: vec = '{16'h0001, 16'h0002, func_cmp, 1'b0};
      6'd31: vec = '{16'hffff, 16'hffff, func_cmp, 1'b0};
      6'd32: vec = '{16'hffff, 16'h0001, func_cmp, 1'b0};
      6'd33: vec = '{16'h8000, 16'h0001, func_cmp, 1'b0};
      6'd34: vec = '{16'h1a62, 16'hed8a, func_cmp, 1'b0};
      6'd35: vec = '{16'haa97, 16'h3b46, func_cmp, 1'b1};
      // Past the end of the table
      default: vec = '0;
    endcase
  end

endmodule

// ==== list.f ====
+incdir+tests
design/alu_pkg.sv
design/vector_pkg.sv
design/alu_req_if.sv
design/vector_rom.sv
design/step_sequencer.sv
design/alu_core.sv
design/alu_vector_runner.sv
tests/tb_alu_vector_runner.sv

// ==== tests/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Signed view of a 16-bit word held in an int
function automatic int signed_value(input int u);
  return (u >= 32768) ? u - 65536 : u;
endfunction

// Reference ALU, works in plain integers and chains its own flags
function automatic void alu_reference(
  input  vector_pkg::test_vector_t v,
  inout  logic [15:0]              model_flags,
  output logic [15:0]              model_result
);
  int          ua;
  int          ub;
  int          cin;
  int          full;
  int          sres;
  logic [15:0] r;
  logic        carry;
  logic        aux;
  logic        adding;
  ua = int'(v.a);
  ub = int'(v.b);
  cin = 0;
  if (v.func inside {func_adc, func_sbb}) begin
    cin = (model_flags[flag_c] || v.force_carry) ? 1 : 0;
  end
  if (v.func inside {func_inc, func_dec}) begin
    ub = 1;
  end
  // Negate is 0 - a
  if (v.func == func_neg) begin
    ub = ua;
    ua = 0;
  end
  adding = v.func inside {func_add, func_adc, func_inc};
  if (adding) begin
    full  = ua + ub + cin;
    carry = full > 65535;
    aux   = (ua % 16) + (ub % 16) + cin > 15;
    sres  = signed_value(ua) + signed_value(ub) + cin;
  end else begin
    full  = ua - ub - cin;
    carry = full < 0;
    aux   = (ua % 16) < (ub % 16) + cin;
    sres  = signed_value(ua) - signed_value(ub) - cin;
  end
  r = 16'(full);
  // inc and dec leave C alone
  if (v.func inside {func_inc, func_dec}) begin
    carry = model_flags[flag_c];
  end
  model_flags         = flags_reset;
  model_flags[flag_c] = carry;
  model_flags[flag_p] = ($countones(r[7:0]) % 2) == 0;
  model_flags[flag_a] = aux;
  model_flags[flag_z] = (r == 16'd0);
  model_flags[flag_s] = r[15];
  model_flags[flag_o] = (sres > 32767) || (sres < -32768);
  model_result = (v.func == func_cmp) ? v.a : r;
endfunction

`endif

// ==== tests/tb_alu_vector_runner.sv ====
`timescale 1ns/1ns

module tb_alu_vector_runner;
  import alu_pkg::*;
  import vector_pkg::*;

  `include "alu_model.svh"

  // 40 vectors at 20 cycles each
  localparam int timeout_cycles = 40 * 20;

  localparam test_vector_t vectors [vector_count] = '{
    '{16'hffff, 16'h0001, func_add, 1'b0}, '{16'hffff, 16'hffff, func_add, 1'b0},
    '{16'h0001, 16'h0002, func_add, 1'b0}, '{16'h7fff, 16'h0001, func_add, 1'b0},
    '{16'h8000, 16'hffff, func_add, 1'b0}, '{16'h1a62, 16'hed8a, func_add, 1'b0},
    '{16'hffff, 16'hffff, func_adc, 1'b0}, '{16'h0001, 16'h0002, func_adc, 1'b0},
    '{16'h7fff, 16'h0001, func_adc, 1'b0}, '{16'h8000, 16'hffff, func_adc, 1'b0},
    '{16'h027f, 16'h846c, func_adc, 1'b0}, '{16'hffff, 16'h0000, func_inc, 1'b0},
    '{16'h7fff, 16'h0000, func_inc, 1'b0}, '{16'h4513, 16'h0000, func_inc, 1'b0},
    '{16'h0000, 16'h0000, func_dec, 1'b0}, '{16'h8000, 16'h0000, func_dec, 1'b0},
    '{16'hc7db, 16'h0000, func_dec, 1'b0}, '{16'h0000, 16'h0000, func_neg, 1'b0},
    '{16'h8000, 16'h0000, func_neg, 1'b0}, '{16'hfac4, 16'h0000, func_neg, 1'b0},
    '{16'h0001, 16'h0002, func_sub, 1'b0}, '{16'hffff, 16'hffff, func_sub, 1'b0},
    '{16'hffff, 16'h0001, func_sub, 1'b0}, '{16'h8000, 16'h0001, func_sub, 1'b0},
    '{16'ha627, 16'h03c5, func_sub, 1'b1}, '{16'h0001, 16'h0002, func_sbb, 1'b0},
    '{16'hffff, 16'hffff, func_sbb, 1'b0}, '{16'hffff, 16'h0001, func_sbb, 1'b0},
    '{16'h8000, 16'h0001, func_sbb, 1'b0}, '{16'ha627, 16'h03c5, func_sbb, 1'b1},
    '{16'h0001, 16'h0002, func_cmp, 1'b0}, '{16'hffff, 16'hffff, func_cmp, 1'b0},
    '{16'hffff, 16'h0001, func_cmp, 1'b0}, '{16'h8000, 16'h0001, func_cmp, 1'b0},
    '{16'h1a62, 16'hed8a, func_cmp, 1'b0}, '{16'haa97, 16'h3b46, func_cmp, 1'b1}
  };

  logic                  clk_1M;
  logic                  reset;
  logic                  sw0_n;
  logic                  sw1_n;
  logic [7:0]            led;
  logic [word_width-1:0] result;
  logic [15:0]           flags;
  logic [15:0]           model_flags;
  // Expected result of the last issued vector
  logic [15:0]           last_result;
  string                 test_name;
  int                    errors      = 0;
  int                    test_errors = 0;
  int                    tests_run   = 0;
  int                    cycle_count = 0;

  alu_vector_runner #(.width(word_width)) uut (
    .clk_1M (clk_1M),
    .reset  (reset),
    .sw0_n  (sw0_n),
    .sw1_n  (sw1_n),
    .led    (led),
    .result (result),
    .flags  (flags)
  );

  initial begin
    clk_1M = 1'b0;
    forever #2 clk_1M = ~clk_1M;
  end

  always @(posedge clk_1M) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic finish_test();
    $display("test %-12s %0d failed checks", test_name, test_errors);
  endtask

  // Drive one switch low for a number of cycles, then release it
  task automatic hold_switch(input bit use_sw1, input int cycles);
    if (use_sw1) begin
      sw1_n = 1'b0;
    end else begin
      sw0_n = 1'b0;
    end
    repeat (cycles) @(negedge clk_1M);
    sw0_n = 1'b1;
    sw1_n = 1'b1;
  endtask

  // Press the switch for vector n, wait for the issue and check the result
  task automatic issue_vector(input int n);
    logic [7:0]  led_before;
    logic [15:0] exp_result;
    logic        old_c;
    led_before = led;
    old_c      = model_flags[flag_c];
    alu_reference(vectors[n], model_flags, exp_result);
    last_result = exp_result;
    if (n % 2 == 1) begin
      sw0_n = 1'b0;
    end else if (n > 0) begin
      sw1_n = 1'b0;
    end
    while (led == led_before) begin
      @(negedge clk_1M);
    end
    sw0_n = 1'b1;
    sw1_n = 1'b1;
    check_value($sformatf("led %0d", n), 16'(n + 1), 16'(led));
    @(negedge clk_1M);
    check_value($sformatf("result %0d", n), exp_result, result);
    check_value($sformatf("flags %0d", n), model_flags, flags);
    if (vectors[n].func inside {func_inc, func_dec}) begin
      check_value($sformatf("kept C %0d", n), 16'(old_c), 16'(flags[flag_c]));
    end
    if (vectors[n].func == func_cmp) begin
      check_value($sformatf("cmp result %0d", n), vectors[n].a, result);
    end
    if (n inside {3, 4, 12, 15, 18}) begin
      check_value($sformatf("O flag %0d", n), 16'd1, 16'(flags[flag_o]));
    end
  endtask

  task automatic test_reset();
    start_test("reset");
    check_value("led", 16'd0, 16'(led));
    check_value("flags", 16'h0002, flags);
    check_value("result", 16'h0000, result);
    issue_vector(0);
    // Z, A, P and C on top of bit 1
    check_value("flags 0 literal", 16'h0057, flags);
    finish_test();
  endtask

  task automatic run_vectors(input string name, input int first, input int last);
    start_test(name);
    for (int n = first; n <= last; n++) begin
      issue_vector(n);
    end
    finish_test();
  endtask

  // Next vector is 11 and wants sw0, sw1 also issued vector 10
  task automatic test_wrong_switch();
    start_test("wrong_sw");
    hold_switch(1'b1, 10);
    check_value("led", 16'd11, 16'(led));
    check_value("result", last_result, result);
    check_value("flags", model_flags, flags);
    finish_test();
  endtask

  task automatic test_after_last();
    start_test("after_last");
    hold_switch(1'b0, 10);
    hold_switch(1'b1, 10);
    check_value("led", 16'd36, 16'(led));
    check_value("result", last_result, result);
    check_value("flags", model_flags, flags);
    finish_test();
  endtask

  initial begin
    reset       = 1'b1;
    sw0_n       = 1'b1;
    sw1_n       = 1'b1;
    model_flags = flags_reset;
    repeat (5) @(negedge clk_1M);
    reset = 1'b0;
    test_reset();
    run_vectors("add_adc", 1, 10);
    test_wrong_switch();
    run_vectors("inc_dec_neg", 11, 19);
    run_vectors("sub_sbb_cmp", 20, 35);
    test_after_last();
    $display("%0d tests run, %0d checks failed", tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
